/* Makefile */
TOP := tb_glbl_cfg

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf obj_dir

/* glbl_cfg.sv */
// Global config and status register block, three stage register bus pipeline
`timescale 1ns/10ps

module glbl_cfg (
    input  logic                   mclk,
    input  logic                   reset_n,

    // Register bus
    input  glbl_cfg_pkg::reg_req_t req,
    output glbl_cfg_pkg::reg_rsp_t rsp,

    // RISC hart identity and interrupt control
    output glbl_cfg_pkg::hart_id_t fuse_mhartid,
    output glbl_cfg_pkg::irq_cfg_t irq_cfg,

    // SDRAM controller setup and status
    input  logic                   sdr_init_done,
    output glbl_cfg_pkg::sdr_cfg_t sdr_cfg
);

    //-----------------------------------------------------------------------
    // Stage links
    //-----------------------------------------------------------------------
    // Captured access, shared by the bank and the response stage
    glbl_cfg_pkg::stage_req_t stage;
    // Register contents for the read mux
    glbl_cfg_pkg::reg_file_t  regs;

    //-----------------------------------------------------------------------
    // Stage 1, request capture
    //-----------------------------------------------------------------------
    glbl_cfg_req_capture u_capture (
        .mclk    (mclk),
        .reset_n (reset_n),
        .req     (req),
        .stage   (stage)
    );

    //-----------------------------------------------------------------------
    // Stage 2, register bank
    //-----------------------------------------------------------------------
    glbl_cfg_regbank u_regbank (
        .mclk          (mclk),
        .reset_n       (reset_n),
        .stage         (stage),
        .sdr_init_done (sdr_init_done),
        .regs          (regs),
        .fuse_mhartid  (fuse_mhartid),
        .irq_cfg       (irq_cfg),
        .sdr_cfg       (sdr_cfg)
    );

    //-----------------------------------------------------------------------
    // Stage 3, read data and ack
    //-----------------------------------------------------------------------
    // Same edge as the bank write
    glbl_cfg_read_resp u_resp (
        .mclk    (mclk),
        .reset_n (reset_n),
        .stage   (stage),
        .regs    (regs),
        .rsp     (rsp)
    );

endmodule

/* glbl_cfg_consts.svh */
// Global config block constants: bus widths, register map and reset values
`ifndef GLBL_CFG_CONSTS_SVH
`define GLBL_CFG_CONSTS_SVH

//---------------------------------------------------------------------------
// Bus widths
//---------------------------------------------------------------------------
// Register word
`define GLBL_CFG_DATA_W        32
// Byte address from the bus master
`define GLBL_CFG_ADDR_W        8
// Word index, taken from byte address bits 5..2
`define GLBL_CFG_IDX_W         4
`define GLBL_CFG_IDX_LSB       2
// Byte lanes
`define GLBL_CFG_BE_W          4
`define GLBL_CFG_BYTE_W        8

//---------------------------------------------------------------------------
// Register map
//---------------------------------------------------------------------------
`define GLBL_CFG_NUM_REGS      6
`define GLBL_CFG_IDX_SCRATCH0  0
`define GLBL_CFG_IDX_HARTID    1
`define GLBL_CFG_IDX_SCRATCH2  2
`define GLBL_CFG_IDX_IRQ       3
`define GLBL_CFG_IDX_SDR_CTRL1 4
`define GLBL_CFG_IDX_SDR_CTRL2 5

//---------------------------------------------------------------------------
// Reset values, the others come up as zero
//---------------------------------------------------------------------------
`define GLBL_CFG_RST_SCRATCH0  32'hDDCC_BBAA
`define GLBL_CFG_RST_HARTID    32'hA55A_A55A
`define GLBL_CFG_RST_SCRATCH2  32'hAABB_CCDD

// Implemented bits of the interrupt word, the rest read zero
`define GLBL_CFG_IRQ_USED_W    20
// Writable bits of SDRAM control word 1, init-done status sits just above
`define GLBL_CFG_SDR1_USED_W   30

`endif

/* glbl_cfg_pkg.sv */
// Global config block types: register bus, pipeline stage and config outputs
`include "glbl_cfg_consts.svh"

package glbl_cfg_pkg;

    //-----------------------------------------------------------------------
    // Plain vector types
    //-----------------------------------------------------------------------
    typedef logic [`GLBL_CFG_DATA_W-1:0] data_t;
    typedef logic [`GLBL_CFG_ADDR_W-1:0] byte_addr_t;
    typedef logic [`GLBL_CFG_IDX_W-1:0]  reg_idx_t;
    typedef logic [`GLBL_CFG_BE_W-1:0]   be_t;
    typedef logic [`GLBL_CFG_DATA_W-1:0] hart_id_t;

    // Request from the bus master, held until ack
    typedef struct packed {
        logic       cs;
        logic       wr;
        byte_addr_t addr;
        data_t      wdata;
        be_t        be;
    } reg_req_t;

    // Response back to the master
    typedef struct packed {
        data_t rdata;
        logic  ack;
    } reg_rsp_t;

    // Captured access between capture, register bank and response stages
    typedef struct packed {
        logic     rd_en;
        logic     wr_en;
        reg_idx_t idx;
        data_t    wdata;
        be_t      be;
        // Access already under way, no second ack
        logic     rpt;
    } stage_req_t;

    // Interrupt control outputs
    typedef struct packed {
        logic [15:0] irq_lines;
        logic        soft_irq;
        logic [2:0]  user_irq;
    } irq_cfg_t;

    // SDRAM controller setup
    typedef struct packed {
        logic [1:0]  sdr_width;
        logic [1:0]  colbits;
        logic [3:0]  tras_d;
        logic [3:0]  trp_d;
        logic [3:0]  trcd_d;
        logic [3:0]  trcar_d;
        logic [3:0]  twr_d;
        logic [1:0]  req_depth;
        logic [2:0]  cas;
        logic        sdr_en;
        logic [2:0]  rfmax;
        logic [12:0] mode_reg;
        logic [11:0] rfsh;
    } sdr_cfg_t;

    // All implemented words, index 0 in the low slot
    typedef data_t [`GLBL_CFG_NUM_REGS-1:0] reg_file_t;

endpackage

/* glbl_cfg_read_resp.sv */
// Global config stage 3: read word select, read data and acknowledge
`timescale 1ns/10ps
`include "glbl_cfg_consts.svh"

module glbl_cfg_read_resp (
    input  logic                     mclk,
    input  logic                     reset_n,
    input  glbl_cfg_pkg::stage_req_t stage,
    input  glbl_cfg_pkg::reg_file_t  regs,
    output glbl_cfg_pkg::reg_rsp_t   rsp
);

    //-----------------------------------------------------------------------
    // Read select
    //-----------------------------------------------------------------------
    glbl_cfg_pkg::data_t rd_word;
    // First cycle of an access that has not been acked yet
    logic                acc_new;

    // Unmapped indices 6..15 fall through as zero
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < `GLBL_CFG_NUM_REGS; i++) begin
            if (stage.idx == glbl_cfg_pkg::reg_idx_t'(i)) begin
                rd_word = regs[i];
            end
        end
    end

    //-----------------------------------------------------------------------
    // Ack qualification
    //-----------------------------------------------------------------------
    // rpt covers every cycle where the master still holds cs after ack
    assign acc_new = (stage.rd_en | stage.wr_en) & ~stage.rpt;

    //-----------------------------------------------------------------------
    // Response register
    //-----------------------------------------------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            rsp.rdata <= '0;
            rsp.ack   <= 1'b0;
        end else begin
            // One cycle pulse per access
            rsp.ack <= acc_new;

            // Read data loaded only on a read and held until the next one
            if (acc_new && stage.rd_en) begin
                rsp.rdata <= rd_word;
            end
        end
    end

endmodule

/* glbl_cfg_regbank.sv */
// Global config stage 2: register bank with byte-lane writes and config fields
`timescale 1ns/10ps
`include "glbl_cfg_consts.svh"

module glbl_cfg_regbank (
    input  logic                     mclk,
    input  logic                     reset_n,
    input  glbl_cfg_pkg::stage_req_t stage,
    input  logic                     sdr_init_done,
    output glbl_cfg_pkg::reg_file_t  regs,
    output glbl_cfg_pkg::hart_id_t   fuse_mhartid,
    output glbl_cfg_pkg::irq_cfg_t   irq_cfg,
    output glbl_cfg_pkg::sdr_cfg_t   sdr_cfg
);

    //-----------------------------------------------------------------------
    // Storage
    //-----------------------------------------------------------------------
    glbl_cfg_pkg::data_t                scratch0_q;
    glbl_cfg_pkg::data_t                hartid_q;
    glbl_cfg_pkg::data_t                scratch2_q;
    // Only the implemented interrupt bits
    logic [`GLBL_CFG_IRQ_USED_W-1:0]    irq_q;
    // Bits 29..0 of SDRAM control word 1
    logic [`GLBL_CFG_SDR1_USED_W-1:0]   sdr_ctrl1_q;
    glbl_cfg_pkg::data_t                sdr_ctrl2_q;

    // Per register write select
    logic [`GLBL_CFG_NUM_REGS-1:0]      wr_sel;
    // Current word with the written bytes merged in
    glbl_cfg_pkg::reg_file_t            wr_word;

    // Replace the enabled byte lanes of cur with wdata
    function automatic glbl_cfg_pkg::data_t be_merge(
        input glbl_cfg_pkg::data_t cur,
        input glbl_cfg_pkg::data_t wdata,
        input glbl_cfg_pkg::be_t   be
    );
        glbl_cfg_pkg::data_t res;
        res = cur;
        for (int b = 0; b < `GLBL_CFG_BE_W; b++) begin
            if (be[b]) begin
                res[b*`GLBL_CFG_BYTE_W +: `GLBL_CFG_BYTE_W] =
                    wdata[b*`GLBL_CFG_BYTE_W +: `GLBL_CFG_BYTE_W];
            end
        end
        return res;
    endfunction

    //-----------------------------------------------------------------------
    // Write decode
    //-----------------------------------------------------------------------
    // Indices 6..15 match nothing, so writes there drop out here
    always_comb begin
        for (int i = 0; i < `GLBL_CFG_NUM_REGS; i++) begin
            wr_sel[i]  = stage.wr_en && (stage.idx == glbl_cfg_pkg::reg_idx_t'(i));
            wr_word[i] = be_merge(regs[i], stage.wdata, stage.be);
        end
    end

    //-----------------------------------------------------------------------
    // Registers
    //-----------------------------------------------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            scratch0_q  <= `GLBL_CFG_RST_SCRATCH0;
            hartid_q    <= `GLBL_CFG_RST_HARTID;
            scratch2_q  <= `GLBL_CFG_RST_SCRATCH2;
            irq_q       <= '0;
            sdr_ctrl1_q <= '0;
            sdr_ctrl2_q <= '0;
        end else begin
            if (wr_sel[`GLBL_CFG_IDX_SCRATCH0]) begin
                scratch0_q <= wr_word[`GLBL_CFG_IDX_SCRATCH0];
            end
            if (wr_sel[`GLBL_CFG_IDX_HARTID]) begin
                hartid_q <= wr_word[`GLBL_CFG_IDX_HARTID];
            end
            if (wr_sel[`GLBL_CFG_IDX_SCRATCH2]) begin
                scratch2_q <= wr_word[`GLBL_CFG_IDX_SCRATCH2];
            end
            // Upper interrupt bits are not kept
            if (wr_sel[`GLBL_CFG_IDX_IRQ]) begin
                irq_q <= wr_word[`GLBL_CFG_IDX_IRQ][`GLBL_CFG_IRQ_USED_W-1:0];
            end
            // Status bit 30 and bit 31 are not writable
            if (wr_sel[`GLBL_CFG_IDX_SDR_CTRL1]) begin
                sdr_ctrl1_q <= wr_word[`GLBL_CFG_IDX_SDR_CTRL1][`GLBL_CFG_SDR1_USED_W-1:0];
            end
            if (wr_sel[`GLBL_CFG_IDX_SDR_CTRL2]) begin
                sdr_ctrl2_q <= wr_word[`GLBL_CFG_IDX_SDR_CTRL2];
            end
        end
    end

    //-----------------------------------------------------------------------
    // Register file view for the read mux
    //-----------------------------------------------------------------------
    always_comb begin
        regs = '0;
        regs[`GLBL_CFG_IDX_SCRATCH0] = scratch0_q;
        regs[`GLBL_CFG_IDX_HARTID]   = hartid_q;
        regs[`GLBL_CFG_IDX_SCRATCH2] = scratch2_q;
        regs[`GLBL_CFG_IDX_IRQ][`GLBL_CFG_IRQ_USED_W-1:0] = irq_q;
        regs[`GLBL_CFG_IDX_SDR_CTRL1][`GLBL_CFG_SDR1_USED_W-1:0] = sdr_ctrl1_q;
        // Live SDRAM init status
        regs[`GLBL_CFG_IDX_SDR_CTRL1][`GLBL_CFG_SDR1_USED_W] = sdr_init_done;
        regs[`GLBL_CFG_IDX_SDR_CTRL2] = sdr_ctrl2_q;
    end

    //-----------------------------------------------------------------------
    // Config outputs, straight from the flops
    //-----------------------------------------------------------------------
    assign fuse_mhartid = hartid_q;

    always_comb begin
        irq_cfg.irq_lines = irq_q[15:0];
        irq_cfg.soft_irq  = irq_q[16];
        irq_cfg.user_irq  = irq_q[19:17];
    end

    always_comb begin
        // Control word 1
        sdr_cfg.sdr_width = sdr_ctrl1_q[1:0];
        sdr_cfg.colbits   = sdr_ctrl1_q[3:2];
        sdr_cfg.tras_d    = sdr_ctrl1_q[7:4];
        sdr_cfg.trp_d     = sdr_ctrl1_q[11:8];
        sdr_cfg.trcd_d    = sdr_ctrl1_q[15:12];
        sdr_cfg.trcar_d   = sdr_ctrl1_q[19:16];
        sdr_cfg.twr_d     = sdr_ctrl1_q[23:20];
        sdr_cfg.req_depth = sdr_ctrl1_q[25:24];
        sdr_cfg.cas       = sdr_ctrl1_q[28:26];
        sdr_cfg.sdr_en    = sdr_ctrl1_q[29];
        // Control word 2, bits 31..28 stored but unused
        sdr_cfg.rfmax     = sdr_ctrl2_q[2:0];
        sdr_cfg.mode_reg  = sdr_ctrl2_q[15:3];
        sdr_cfg.rfsh      = sdr_ctrl2_q[27:16];
    end

endmodule

/* glbl_cfg_req_capture.sv */
// Global config stage 1: registers the bus request and flags repeat cycles
`timescale 1ns/10ps
`include "glbl_cfg_consts.svh"

module glbl_cfg_req_capture (
    input  logic                     mclk,
    input  logic                     reset_n,
    input  glbl_cfg_pkg::reg_req_t   req,
    output glbl_cfg_pkg::stage_req_t stage
);

    //-----------------------------------------------------------------------
    // Chip select history
    //-----------------------------------------------------------------------
    // First delay flop, the second one is stage.rpt
    logic cs_d1;

    //-----------------------------------------------------------------------
    // Request register
    //-----------------------------------------------------------------------
    // Everything from the bus is flopped once so the bus sees no
    // combinational path into the register bank
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            cs_d1       <= 1'b0;
            stage.rd_en <= 1'b0;
            stage.wr_en <= 1'b0;
            stage.rpt   <= 1'b0;
            stage.idx   <= '0;
            stage.wdata <= '0;
            stage.be    <= '0;
        end else begin
            // Split cs into read and write strobes
            stage.rd_en <= req.cs & ~req.wr;
            stage.wr_en <= req.cs & req.wr;

            // Word index from byte address
            stage.idx   <= req.addr[`GLBL_CFG_IDX_LSB +: `GLBL_CFG_IDX_W];

            // Payload
            stage.wdata <= req.wdata;
            stage.be    <= req.be;

            // cs delayed twice
            // High while the master still holds an access that was already
            // acknowledged or is about to be
            cs_d1       <= req.cs;
            stage.rpt   <= cs_d1;
        end
    end

endmodule

/* glbl_cfg_sva.sv */
// Global config bus assertions: single ack pulse, fixed latency and reset state
`timescale 1ns/10ps

module glbl_cfg_sva (
    input logic                   mclk,
    input logic                   reset_n,
    input glbl_cfg_pkg::reg_req_t req,
    input glbl_cfg_pkg::reg_rsp_t rsp
);

    //-------------------------------------------------------------------------
    // Bus protocol
    //-------------------------------------------------------------------------
    // Ack is a one-cycle pulse
    ack_pulse: assert property (@(posedge mclk) disable iff (!reset_n)
        rsp.ack |=> !rsp.ack)
        else $error("ack high on two consecutive cycles");

    // Fixed latency from the first sampled cs
    ack_latency: assert property (@(posedge mclk) disable iff (!reset_n)
        $rose(req.cs) |-> ##2 rsp.ack)
        else $error("ack missing two edges after cs rose");

    //-------------------------------------------------------------------------
    // Reset state
    //-------------------------------------------------------------------------
    reset_idle: assert property (@(posedge mclk)
        !reset_n |-> (!rsp.ack && rsp.rdata == '0))
        else $error("response not idle during reset");

endmodule

bind glbl_cfg glbl_cfg_sva u_sva (
    .mclk    (mclk),
    .reset_n (reset_n),
    .req     (req),
    .rsp     (rsp)
);

/* tb_glbl_cfg.sv */
// Testbench for the global config block: bus driver, reference model and checks
`timescale 1ns/10ps
`include "glbl_cfg_consts.svh"

module tb_glbl_cfg;

    localparam int CLK_HALF   = 20;
    localparam int RST_CYCLES = 8;
    // About 140 accesses of 4 cycles plus reset is under 600 cycles
    localparam int MAX_CYCLES = 4000;
    // Ack is due on the second falling edge after cs goes out
    localparam int ACK_WAIT   = 8;

    logic                   mclk;
    logic                   reset_n;
    logic                   sdr_init_done;
    glbl_cfg_pkg::reg_req_t req;
    glbl_cfg_pkg::reg_rsp_t rsp;
    glbl_cfg_pkg::hart_id_t fuse_mhartid;
    glbl_cfg_pkg::irq_cfg_t irq_cfg;
    glbl_cfg_pkg::sdr_cfg_t sdr_cfg;

    // Reference words as written, masking happens on read
    glbl_cfg_pkg::data_t model [`GLBL_CFG_NUM_REGS];
    // Expected read values and names, in issue order
    glbl_cfg_pkg::data_t exp_q [$];
    string               name_q [$];
    glbl_cfg_pkg::data_t rd_cap;
    event                read_done;
    int                  data_errs = 0;
    int                  cfg_errs = 0;
    int                  ack_errs = 0;
    int                  cycles = 0;

    glbl_cfg UUT (
        .mclk          (mclk),
        .reset_n       (reset_n),
        .req           (req),
        .rsp           (rsp),
        .fuse_mhartid  (fuse_mhartid),
        .irq_cfg       (irq_cfg),
        .sdr_init_done (sdr_init_done),
        .sdr_cfg       (sdr_cfg)
    );

    initial begin
        mclk = 1'b0;
        forever #(CLK_HALF) mclk = ~mclk;
    end

    // Run limit
    always @(posedge mclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped at the cycle limit before all tests finished");
            $display("Test failures found");
            $finish;
        end
    end

    //-------------------------------------------------------------------------
    // Reference model
    //-------------------------------------------------------------------------
    function automatic glbl_cfg_pkg::data_t lane_merge(input glbl_cfg_pkg::data_t old_w,
            input glbl_cfg_pkg::data_t new_w, input glbl_cfg_pkg::be_t be);
        glbl_cfg_pkg::data_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // Expected read word under the register map rules
    function automatic glbl_cfg_pkg::data_t ref_read(input int idx, input logic init_done);
        glbl_cfg_pkg::data_t w;
        w = '0;
        if (idx < `GLBL_CFG_NUM_REGS) begin
            w = model[idx];
        end
        if (idx == `GLBL_CFG_IDX_IRQ) begin
            w[31:`GLBL_CFG_IRQ_USED_W] = '0;
        end
        if (idx == `GLBL_CFG_IDX_SDR_CTRL1) begin
            w[31] = 1'b0;
            w[30] = init_done;
        end
        return w;
    endfunction

    function automatic glbl_cfg_pkg::irq_cfg_t ref_irq(input glbl_cfg_pkg::data_t w);
        glbl_cfg_pkg::irq_cfg_t c;
        c.irq_lines = w[15:0];
        c.soft_irq  = w[16];
        c.user_irq  = w[19:17];
        return c;
    endfunction

    // Fields packed upward from bit 0 of each control word
    function automatic glbl_cfg_pkg::sdr_cfg_t ref_sdr(input glbl_cfg_pkg::data_t w1,
            input glbl_cfg_pkg::data_t w2);
        glbl_cfg_pkg::sdr_cfg_t c;
        c.sdr_width = w1[1:0];
        c.colbits   = w1[3:2];
        c.tras_d    = w1[7:4];
        c.trp_d     = w1[11:8];
        c.trcd_d    = w1[15:12];
        c.trcar_d   = w1[19:16];
        c.twr_d     = w1[23:20];
        c.req_depth = w1[25:24];
        c.cas       = w1[28:26];
        c.sdr_en    = w1[29];
        c.rfmax     = w2[2:0];
        c.mode_reg  = w2[15:3];
        c.rfsh      = w2[27:16];
        return c;
    endfunction

    //-------------------------------------------------------------------------
    // Compare tasks
    //-------------------------------------------------------------------------
    task automatic check_data(input string name, input glbl_cfg_pkg::data_t exp,
            input glbl_cfg_pkg::data_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_hart(input string name, input glbl_cfg_pkg::hart_id_t exp,
            input glbl_cfg_pkg::hart_id_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            cfg_errs++;
        end
    endtask

    task automatic check_irq(input string name, input glbl_cfg_pkg::irq_cfg_t exp,
            input glbl_cfg_pkg::irq_cfg_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            cfg_errs++;
        end
    endtask

    task automatic check_sdr(input string name, input glbl_cfg_pkg::sdr_cfg_t exp,
            input glbl_cfg_pkg::sdr_cfg_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            cfg_errs++;
        end
    endtask

    // All config outputs against the model words
    task automatic check_outputs(input string name);
        check_hart({name, " hart"}, model[`GLBL_CFG_IDX_HARTID], fuse_mhartid);
        check_irq({name, " irq"}, ref_irq(model[`GLBL_CFG_IDX_IRQ]), irq_cfg);
        check_sdr({name, " sdr"}, ref_sdr(model[`GLBL_CFG_IDX_SDR_CTRL1],
            model[`GLBL_CFG_IDX_SDR_CTRL2]), sdr_cfg);
    endtask

    // Completed reads, checked in issue order
    always @(read_done) begin
        check_data(name_q.pop_front(), exp_q.pop_front(), rd_cap);
    end

    //-------------------------------------------------------------------------
    // Bus driver, entered and left on a falling edge
    //-------------------------------------------------------------------------
    task automatic bus_access(input logic wr, input int idx, input glbl_cfg_pkg::data_t wdata,
            input glbl_cfg_pkg::be_t be);
        int waited;
        req.cs    = 1'b1;
        req.wr    = wr;
        req.addr  = glbl_cfg_pkg::byte_addr_t'(idx << 2);
        req.wdata = wdata;
        req.be    = be;
        waited    = 0;
        do begin
            @(negedge mclk);
            waited++;
        end while (!rsp.ack && waited < ACK_WAIT);
        if (!rsp.ack) begin
            $display("No ack came back for the access to index %0d", idx);
            ack_errs++;
        end
        rd_cap = rsp.rdata;
        req.cs = 1'b0;
        // Idle gap between accesses
        repeat (2) @(negedge mclk);
    endtask

    task automatic write_reg(input int idx, input glbl_cfg_pkg::data_t wdata,
            input glbl_cfg_pkg::be_t be);
        if (idx < `GLBL_CFG_NUM_REGS) begin
            model[idx] = lane_merge(model[idx], wdata, be);
        end
        bus_access(1'b1, idx, wdata, be);
    endtask

    task automatic read_reg(input string name, input int idx);
        exp_q.push_back(ref_read(idx, sdr_init_done));
        name_q.push_back(name);
        bus_access(1'b0, idx, '0, '0);
        -> read_done;
    endtask

    //-------------------------------------------------------------------------
    // Test sequence
    //-------------------------------------------------------------------------
    initial begin
        int                  idx;
        glbl_cfg_pkg::data_t w;
        glbl_cfg_pkg::data_t r;
        void'($urandom(3597));
        req           = '0;
        reset_n       = 1'b0;
        sdr_init_done = 1'b0;
        for (int i = 0; i < `GLBL_CFG_NUM_REGS; i++) begin
            model[i] = '0;
        end
        model[`GLBL_CFG_IDX_SCRATCH0] = `GLBL_CFG_RST_SCRATCH0;
        model[`GLBL_CFG_IDX_HARTID]   = `GLBL_CFG_RST_HARTID;
        model[`GLBL_CFG_IDX_SCRATCH2] = `GLBL_CFG_RST_SCRATCH2;
        repeat (RST_CYCLES) @(posedge mclk);
        @(negedge mclk);
        reset_n = 1'b1;
        repeat (2) @(negedge mclk);

        // Reset contents
        check_outputs("reset");
        for (int i = 0; i < `GLBL_CFG_NUM_REGS; i++) begin
            read_reg("reset_read", i);
        end

        // Full words, every register
        for (int n = 0; n < 4; n++) begin
            for (int i = 0; i < `GLBL_CFG_NUM_REGS; i++) begin
                w = $urandom();
                write_reg(i, w, 4'hF);
                read_reg("full_word", i);
                check_outputs("full_word");
            end
        end

        // Random byte lanes
        for (int n = 0; n < 24; n++) begin
            idx = $urandom_range(`GLBL_CFG_NUM_REGS - 1, 0);
            w   = $urandom();
            r   = $urandom();
            write_reg(idx, w, r[3:0]);
            read_reg("byte_lane", idx);
            check_outputs("byte_lane");
        end

        // Init-done status, not writable
        write_reg(`GLBL_CFG_IDX_SDR_CTRL1, 32'hFFFF_FFFF, 4'hF);
        read_reg("init_done_low", `GLBL_CFG_IDX_SDR_CTRL1);
        sdr_init_done = 1'b1;
        read_reg("init_done_high", `GLBL_CFG_IDX_SDR_CTRL1);
        write_reg(`GLBL_CFG_IDX_SDR_CTRL1, 32'h0000_0000, 4'hF);
        read_reg("init_done_kept", `GLBL_CFG_IDX_SDR_CTRL1);
        sdr_init_done = 1'b0;
        read_reg("init_done_clear", `GLBL_CFG_IDX_SDR_CTRL1);
        check_outputs("init_done");

        // Unmapped indices
        for (int i = `GLBL_CFG_NUM_REGS; i < 16; i++) begin
            w = $urandom();
            write_reg(i, w, 4'hF);
            read_reg("unmapped", i);
        end
        for (int i = 0; i < `GLBL_CFG_NUM_REGS; i++) begin
            read_reg("after_unmapped", i);
        end
        check_outputs("after_unmapped");

        // Let the last compare run
        @(negedge mclk);
        $display("Errors: data %0d, config %0d, ack %0d", data_errs, cfg_errs, ack_errs);
        if (data_errs + cfg_errs + ack_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
glbl_cfg_pkg.sv
glbl_cfg_req_capture.sv
glbl_cfg_regbank.sv
glbl_cfg_read_resp.sv
glbl_cfg.sv
glbl_cfg_sva.sv
tb_glbl_cfg.sv
